//--- common/mips_defines.svh
/*
 * MIPS decode constants
 * data and register-address widths, opcode and function codes
 */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_DATA_W 32
`define MIPS_REG_AW 5
`define MIPS_IMM_W  16

// primary opcodes
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_ADDI    6'b001000
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_SLTI    6'b001010
`define MIPS_OP_SLTIU   6'b001011
`define MIPS_OP_ANDI    6'b001100
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_XORI    6'b001110
`define MIPS_OP_LUI     6'b001111

// function codes under the special opcode
`define MIPS_FN_SLL  6'b000000
`define MIPS_FN_SRL  6'b000010
`define MIPS_FN_SRA  6'b000011
`define MIPS_FN_SLLV 6'b000100
`define MIPS_FN_SRLV 6'b000110
`define MIPS_FN_SRAV 6'b000111
`define MIPS_FN_ADD  6'b100000
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUB  6'b100010
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND  6'b100100
`define MIPS_FN_OR   6'b100101
`define MIPS_FN_XOR  6'b100110
`define MIPS_FN_NOR  6'b100111
`define MIPS_FN_SLT  6'b101010
`define MIPS_FN_SLTU 6'b101011

`endif

//--- common/mips_pkg.sv
/*
 * MIPS decode types
 * instruction word views, ALU operation codes and the
 * register-write and execute-stage bundles
 */
`include "mips_defines.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]              op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rtype_t;

    typedef struct packed {
        logic [5:0]              op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_IMM_W-1:0]  imm16;
    } itype_t;

    // one instruction word read as either format
    typedef union packed {
        rtype_t r;
        itype_t i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH
    } alu_sel_e;

    // writeback and forwarding ports
    typedef struct packed {
        logic                    en;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        alu_op_e                 alu_op;
        alu_sel_e                alu_sel;
        logic [`MIPS_DATA_W-1:0] op1;
        logic [`MIPS_DATA_W-1:0] op2;
        logic [`MIPS_REG_AW-1:0] wr_addr;
        logic                    wr_en;
    } id_ex_t;

endpackage

//--- decode/inst_decoder.sv
/*
 * Instruction decoder
 * turns one MIPS word into ALU control, register read
 * requests, destination and immediate
 */
`timescale 1ns/1ps
`include "mips_defines.svh"

module inst_decoder (
    input  mips_pkg::inst_u         inst_i,
    output mips_pkg::alu_op_e       alu_op_o,
    output mips_pkg::alu_sel_e      alu_sel_o,
    output logic                    rs_re_o,
    output logic                    rt_re_o,
    output logic [`MIPS_REG_AW-1:0] rs_addr_o,
    output logic [`MIPS_REG_AW-1:0] rt_addr_o,
    output logic [`MIPS_REG_AW-1:0] wr_addr_o,
    output logic                    wr_en_o,
    output logic [`MIPS_DATA_W-1:0] imm_o
);

    localparam int EXT_W = `MIPS_DATA_W - `MIPS_IMM_W;

    logic [`MIPS_DATA_W-1:0] imm_zext;
    logic [`MIPS_DATA_W-1:0] imm_sext;
    logic                    shift_imm_form;

    assign imm_zext = {{EXT_W{1'b0}}, inst_i.i.imm16};
    assign imm_sext = {{EXT_W{inst_i.i.imm16[`MIPS_IMM_W-1]}}, inst_i.i.imm16};

    // sll/srl/sra only when op and rs are all zero
    assign shift_imm_form = ({inst_i.r.op, inst_i.r.rs} == '0);

    always_comb begin
        alu_op_o  = mips_pkg::ALU_NOP;
        alu_sel_o = mips_pkg::SEL_NOP;
        rs_re_o   = 1'b1;
        rt_re_o   = 1'b1;
        rs_addr_o = inst_i.r.rs;
        rt_addr_o = inst_i.r.rt;
        wr_addr_o = inst_i.r.rd;
        wr_en_o   = 1'b0;
        imm_o     = '0;

        case (inst_i.r.op)
            `MIPS_OP_SPECIAL: begin
                if (inst_i.r.shamt == '0) begin
                    wr_en_o = 1'b1;
                    case (inst_i.r.funct)
                        `MIPS_FN_OR:   alu_op_o = mips_pkg::ALU_OR;
                        `MIPS_FN_AND:  alu_op_o = mips_pkg::ALU_AND;
                        `MIPS_FN_XOR:  alu_op_o = mips_pkg::ALU_XOR;
                        `MIPS_FN_NOR:  alu_op_o = mips_pkg::ALU_NOR;
                        `MIPS_FN_SLLV: alu_op_o = mips_pkg::ALU_SLL;
                        `MIPS_FN_SRLV: alu_op_o = mips_pkg::ALU_SRL;
                        `MIPS_FN_SRAV: alu_op_o = mips_pkg::ALU_SRA;
                        `MIPS_FN_ADD:  alu_op_o = mips_pkg::ALU_ADD;
                        `MIPS_FN_ADDU: alu_op_o = mips_pkg::ALU_ADDU;
                        `MIPS_FN_SUB:  alu_op_o = mips_pkg::ALU_SUB;
                        `MIPS_FN_SUBU: alu_op_o = mips_pkg::ALU_SUBU;
                        `MIPS_FN_SLT:  alu_op_o = mips_pkg::ALU_SLT;
                        `MIPS_FN_SLTU: alu_op_o = mips_pkg::ALU_SLTU;
                        default:       wr_en_o  = 1'b0;
                    endcase
                    case (alu_op_o)
                        mips_pkg::ALU_NOP: alu_sel_o = mips_pkg::SEL_NOP;
                        mips_pkg::ALU_OR,
                        mips_pkg::ALU_AND,
                        mips_pkg::ALU_XOR,
                        mips_pkg::ALU_NOR: alu_sel_o = mips_pkg::SEL_LOGIC;
                        mips_pkg::ALU_SLL,
                        mips_pkg::ALU_SRL,
                        mips_pkg::ALU_SRA: alu_sel_o = mips_pkg::SEL_SHIFT;
                        default:           alu_sel_o = mips_pkg::SEL_ARITH;
                    endcase
                end
            end
            `MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI, `MIPS_OP_LUI: begin
                alu_sel_o = mips_pkg::SEL_LOGIC;
                rt_re_o   = 1'b0;
                wr_addr_o = inst_i.i.rt;
                wr_en_o   = 1'b1;
                imm_o     = imm_zext;
                case (inst_i.i.op)
                    `MIPS_OP_ANDI: alu_op_o = mips_pkg::ALU_AND;
                    `MIPS_OP_XORI: alu_op_o = mips_pkg::ALU_XOR;
                    default:       alu_op_o = mips_pkg::ALU_OR;
                endcase
                // lui is an or of rs with the upper-half immediate
                if (inst_i.i.op == `MIPS_OP_LUI) begin
                    imm_o = {inst_i.i.imm16, {EXT_W{1'b0}}};
                end
            end
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU: begin
                alu_sel_o = mips_pkg::SEL_ARITH;
                rt_re_o   = 1'b0;
                wr_addr_o = inst_i.i.rt;
                wr_en_o   = 1'b1;
                imm_o     = imm_sext;
                case (inst_i.i.op)
                    `MIPS_OP_ADDI:  alu_op_o = mips_pkg::ALU_ADD;
                    `MIPS_OP_ADDIU: alu_op_o = mips_pkg::ALU_ADDU;
                    `MIPS_OP_SLTI:  alu_op_o = mips_pkg::ALU_SLT;
                    default:        alu_op_o = mips_pkg::ALU_SLTU;
                endcase
            end
            default: begin
            end
        endcase

        // shamt goes to op1 through the immediate path
        if (shift_imm_form) begin
            case (inst_i.r.funct)
                `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA: begin
                    alu_sel_o = mips_pkg::SEL_SHIFT;
                    rs_re_o   = 1'b0;
                    rt_re_o   = 1'b1;
                    wr_addr_o = inst_i.r.rd;
                    wr_en_o   = 1'b1;
                    imm_o     = {{(`MIPS_DATA_W-5){1'b0}}, inst_i.r.shamt};
                    case (inst_i.r.funct)
                        `MIPS_FN_SLL: alu_op_o = mips_pkg::ALU_SLL;
                        `MIPS_FN_SRL: alu_op_o = mips_pkg::ALU_SRL;
                        default:      alu_op_o = mips_pkg::ALU_SRA;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- decode/operand_mux.sv
/*
 * Source operand select
 * immediate, zero register, execute and memory forwarding,
 * then register file data, in that priority
 */
`timescale 1ns/1ps
`include "mips_defines.svh"

module operand_mux (
    input  logic                    re_i,
    input  logic [`MIPS_REG_AW-1:0] addr_i,
    input  logic [`MIPS_DATA_W-1:0] rf_data_i,
    input  logic [`MIPS_DATA_W-1:0] imm_i,
    input  mips_pkg::reg_wr_t       ex_fwd_i,
    input  mips_pkg::reg_wr_t       mem_fwd_i,
    output logic [`MIPS_DATA_W-1:0] operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.en && (ex_fwd_i.addr == addr_i);
    assign mem_hit = mem_fwd_i.en && (mem_fwd_i.addr == addr_i);

    always_comb begin
        if (!re_i) begin
            operand_o = imm_i;
        end else if (addr_i == '0) begin
            // r0 is never forwarded
            operand_o = '0;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

//--- tb/id_ref_model.svh
/*
 * Decode stage reference model
 * shadow register file, instruction decode and operand selection
 */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

logic [`MIPS_DATA_W-1:0] shadow_regs [32];

function automatic logic [`MIPS_DATA_W-1:0] model_operand(
    input logic                    re,
    input logic [`MIPS_REG_AW-1:0] addr,
    input logic [`MIPS_DATA_W-1:0] imm,
    input mips_pkg::reg_wr_t       wb,
    input mips_pkg::reg_wr_t       ex,
    input mips_pkg::reg_wr_t       mem
);
    if (!re) return imm;
    if (addr == '0) return '0;
    if (ex.en && ex.addr == addr) return ex.data;
    if (mem.en && mem.addr == addr) return mem.data;
    // same-cycle writeback is visible to the read
    if (wb.en && wb.addr == addr) return wb.data;
    return shadow_regs[addr];
endfunction

function automatic mips_pkg::alu_sel_e model_class(input mips_pkg::alu_op_e op);
    case (op)
        mips_pkg::ALU_NOP: return mips_pkg::SEL_NOP;
        mips_pkg::ALU_OR, mips_pkg::ALU_AND,
        mips_pkg::ALU_XOR, mips_pkg::ALU_NOR: return mips_pkg::SEL_LOGIC;
        mips_pkg::ALU_SLL, mips_pkg::ALU_SRL,
        mips_pkg::ALU_SRA: return mips_pkg::SEL_SHIFT;
        default: return mips_pkg::SEL_ARITH;
    endcase
endfunction

function automatic mips_pkg::id_ex_t model_bundle(
    input logic [31:0]       w,
    input mips_pkg::reg_wr_t wb,
    input mips_pkg::reg_wr_t ex,
    input mips_pkg::reg_wr_t mem
);
    mips_pkg::id_ex_t b;
    logic [31:0]      imm;
    logic             rs_re;
    logic             rt_re;
    b = '0;
    imm = '0;
    rs_re = 1'b1;
    rt_re = 1'b1;
    b.wr_addr = w[15:11];
    if (w[31:21] == '0 && w[5:2] == 4'b0000 && w[1:0] != 2'b01) begin
        // sll, srl, sra take shamt as op1
        rs_re = 1'b0;
        imm = {27'b0, w[10:6]};
        b.alu_op = w[0] ? mips_pkg::ALU_SRA : (w[1] ? mips_pkg::ALU_SRL : mips_pkg::ALU_SLL);
        b.wr_en = 1'b1;
    end else if (w[31:26] == `MIPS_OP_SPECIAL && w[10:6] == '0) begin
        case (w[5:0])
            `MIPS_FN_OR:   b.alu_op = mips_pkg::ALU_OR;
            `MIPS_FN_AND:  b.alu_op = mips_pkg::ALU_AND;
            `MIPS_FN_XOR:  b.alu_op = mips_pkg::ALU_XOR;
            `MIPS_FN_NOR:  b.alu_op = mips_pkg::ALU_NOR;
            `MIPS_FN_SLLV: b.alu_op = mips_pkg::ALU_SLL;
            `MIPS_FN_SRLV: b.alu_op = mips_pkg::ALU_SRL;
            `MIPS_FN_SRAV: b.alu_op = mips_pkg::ALU_SRA;
            `MIPS_FN_ADD:  b.alu_op = mips_pkg::ALU_ADD;
            `MIPS_FN_ADDU: b.alu_op = mips_pkg::ALU_ADDU;
            `MIPS_FN_SUB:  b.alu_op = mips_pkg::ALU_SUB;
            `MIPS_FN_SUBU: b.alu_op = mips_pkg::ALU_SUBU;
            `MIPS_FN_SLT:  b.alu_op = mips_pkg::ALU_SLT;
            `MIPS_FN_SLTU: b.alu_op = mips_pkg::ALU_SLTU;
            default:       b.alu_op = mips_pkg::ALU_NOP;
        endcase
        b.wr_en = (b.alu_op != mips_pkg::ALU_NOP);
    end else if (w[31:29] == 3'b001) begin
        // immediate forms write rt, op2 is the immediate
        rt_re = 1'b0;
        b.wr_addr = w[20:16];
        b.wr_en = 1'b1;
        imm = w[28] ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        case (w[31:26])
            `MIPS_OP_ADDI:  b.alu_op = mips_pkg::ALU_ADD;
            `MIPS_OP_ADDIU: b.alu_op = mips_pkg::ALU_ADDU;
            `MIPS_OP_SLTI:  b.alu_op = mips_pkg::ALU_SLT;
            `MIPS_OP_SLTIU: b.alu_op = mips_pkg::ALU_SLTU;
            `MIPS_OP_ANDI:  b.alu_op = mips_pkg::ALU_AND;
            `MIPS_OP_ORI:   b.alu_op = mips_pkg::ALU_OR;
            `MIPS_OP_XORI:  b.alu_op = mips_pkg::ALU_XOR;
            `MIPS_OP_LUI: begin
                b.alu_op = mips_pkg::ALU_OR;
                imm = {w[15:0], 16'b0};
            end
        endcase
    end
    b.alu_sel = model_class(b.alu_op);
    b.op1 = model_operand(rs_re, w[25:21], imm, wb, ex, mem);
    b.op2 = model_operand(rt_re, w[20:16], imm, wb, ex, mem);
    return b;
endfunction

`endif

//--- tb/tb_id_stage.sv
/*
 * Decode stage testbench
 * random instructions, writeback and forwarding traffic with
 * a scoreboard against the reference model
 */
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_id_stage;

    logic              clk = 1'b0;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    mips_pkg::inst_u   inst;
    logic              out_valid;
    logic              out_ready;
    mips_pkg::id_ex_t  bundle;
    mips_pkg::reg_wr_t wb;
    mips_pkg::reg_wr_t ex_fwd;
    mips_pkg::reg_wr_t mem_fwd;

    mips_pkg::id_ex_t  exp_q [$];
    mips_pkg::id_ex_t  last_out;
    string             test_name;
    logic              expect_valid;
    int                errors = 0;
    int                checks = 0;
    int                acc_cnt = 0;
    int                tests = 0;
    int                failed = 0;

    `include "id_ref_model.svh"

    id_stage dut_i (
        .clk         (clk),
        .rst_i       (rst),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .inst_i      (inst),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .bundle_o    (bundle),
        .wb_i        (wb),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd)
    );

    always #2 clk = ~clk;

    // scoreboard sampled at the rising edge before any update
    always @(posedge clk) begin
        mips_pkg::id_ex_t exp_b;
        logic             exp_ready;
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow_regs[i] = '0;
            end
            exp_q.delete();
            expect_valid = 1'b0;
        end else begin
            // output register is full while one bundle is outstanding
            exp_ready = (exp_q.size() == 0) || out_ready;
            checks++;
            if (in_ready !== exp_ready) begin
                errors++;
                $display("FAILED %s: in_ready expected %b actual %b",
                         test_name, exp_ready, in_ready);
            end
            if (expect_valid && !out_valid) begin
                errors++;
                $display("ERROR: %s accepted instruction missing one cycle later", test_name);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR: %s output handshake with nothing outstanding", test_name);
                end else begin
                    exp_b = exp_q.pop_front();
                    checks++;
                    if (bundle !== exp_b) begin
                        errors++;
                        $display("FAILED %s: expected %h actual %h", test_name, exp_b, bundle);
                    end
                    last_out = bundle;
                end
            end
            expect_valid = in_valid && in_ready;
            if (expect_valid) begin
                exp_q.push_back(model_bundle(inst, wb, ex_fwd, mem_fwd));
                acc_cnt++;
            end
            if (wb.en && wb.addr != '0) begin
                shadow_regs[wb.addr] = wb.data;
            end
        end
    end

    // small pool so that forwarding hits are frequent
    function automatic logic [4:0] pick_reg();
        if ($urandom % 4 != 0) return 5'($urandom % 4);
        return 5'($urandom);
    endfunction

    function automatic mips_pkg::reg_wr_t rand_port(input int pct);
        mips_pkg::reg_wr_t p;
        p.en = ($urandom % 100) < pct;
        p.addr = pick_reg();
        p.data = $urandom;
        return p;
    endfunction

    function automatic logic [31:0] gen_inst(input int kind);
        int         pick;
        logic [4:0] rs;
        pick = $urandom % 8;
        rs = (kind == 2 && pick < 4) ? 5'b0 : pick_reg();
        if (kind == 2) begin
            return {6'b0, rs, pick_reg(), pick_reg(), (pick < 4) ? 5'($urandom) : 5'b0,
                    3'b000, 3'($urandom)};
        end
        if (kind == 0 && pick == 0) return $urandom;
        if (kind == 1 || pick < 3) begin
            return {6'b0, rs, pick_reg(), pick_reg(), 5'b0, 2'b10, $urandom % 4 == 0,
                    3'($urandom)};
        end
        return {3'b001, 3'($urandom), rs, pick_reg(), 16'($urandom)};
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - err0);
        end
    endtask

    // called at a falling edge
    task automatic drain();
        int cycles;
        cycles = 0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        wb = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        while ((exp_q.size() != 0 || out_valid) && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || out_valid) begin
            errors++;
            $display("ERROR: %s timed out waiting for the output to drain", test_name);
        end
    endtask

    task automatic send_one(input logic [31:0] w);
        int cycles;
        int target;
        cycles = 0;
        target = acc_cnt + 1;
        @(negedge clk);
        in_valid = 1'b1;
        inst = w;
        out_ready = 1'b1;
        while (acc_cnt < target && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (acc_cnt < target) begin
            errors++;
            $display("ERROR: %s instruction was never accepted", test_name);
        end
        drain();
    endtask

    task automatic run_test(input string name, input int kind, input int n, input int fwd_pct,
                            input int wb_pct, input int ready_pct, input int stretch);
        int err0;
        int cycles;
        int target;
        int ready_left;
        err0 = errors;
        cycles = 0;
        ready_left = 0;
        test_name = name;
        target = acc_cnt + n;
        while (acc_cnt < target && cycles < n * 20) begin
            @(negedge clk);
            in_valid = ($urandom % 100) < 70;
            inst = gen_inst(kind);
            wb = rand_port(wb_pct);
            ex_fwd = rand_port(fwd_pct);
            mem_fwd = rand_port(fwd_pct);
            if (ready_left == 0) begin
                out_ready = ($urandom % 100) < ready_pct;
                ready_left = 1 + $urandom % stretch;
            end
            ready_left--;
            cycles++;
        end
        if (acc_cnt < target) begin
            errors++;
            $display("ERROR: %s timed out waiting for input handshakes", name);
        end
        drain();
        finish_test(name, err0);
    endtask

    initial begin
        int err0;
        void'($urandom(32'hdfaa));
        rst = 1'b1;
        in_valid = 1'b0;
        inst = '0;
        out_ready = 1'b0;
        wb = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "reset";
        err0 = errors;
        check_word(test_name, 32'h0, {31'b0, out_valid});
        finish_test(test_name, err0);

        // registers 9 and 10 are still zero here
        test_name = "directed_lui_ori";
        err0 = errors;
        send_one({`MIPS_OP_LUI, 5'd9, 5'd5, 16'h1234});
        check_word(test_name, 32'h12340000, last_out.op2);
        check_word(test_name, 32'h0, last_out.op1);
        send_one({`MIPS_OP_ORI, 5'd10, 5'd6, 16'h8001});
        check_word(test_name, 32'h00008001, last_out.op2);
        finish_test(test_name, err0);

        run_test("random_mix", 0, 300, 20, 30, 70, 1);
        run_test("forwarding", 1, 300, 70, 0, 70, 1);
        run_test("writeback_read", 0, 300, 0, 90, 70, 1);
        run_test("shift_forms", 2, 200, 30, 30, 70, 1);
        run_test("backpressure", 0, 300, 30, 30, 50, 8);

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests, tests - failed, failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/id_stage.sv
/*
 * Instruction decode stage
 * decodes, reads and forwards operands, and registers the
 * execute bundle behind a valid/ready handshake
 */
`timescale 1ns/1ps
`include "mips_defines.svh"

module id_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  mips_pkg::inst_u   inst_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output mips_pkg::id_ex_t  bundle_o,
    input  mips_pkg::reg_wr_t wb_i,
    input  mips_pkg::reg_wr_t ex_fwd_i,
    input  mips_pkg::reg_wr_t mem_fwd_i
);

    mips_pkg::alu_op_e       dec_alu_op;
    mips_pkg::alu_sel_e      dec_alu_sel;
    logic                    rs_re;
    logic                    rt_re;
    logic [`MIPS_REG_AW-1:0] rs_addr;
    logic [`MIPS_REG_AW-1:0] rt_addr;
    logic [`MIPS_REG_AW-1:0] dec_wr_addr;
    logic                    dec_wr_en;
    logic [`MIPS_DATA_W-1:0] dec_imm;
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;
    logic [`MIPS_DATA_W-1:0] op1;
    logic [`MIPS_DATA_W-1:0] op2;
    logic                    accept;

    inst_decoder u_decoder (
        .inst_i    (inst_i),
        .alu_op_o  (dec_alu_op),
        .alu_sel_o (dec_alu_sel),
        .rs_re_o   (rs_re),
        .rt_re_o   (rt_re),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .wr_addr_o (dec_wr_addr),
        .wr_en_o   (dec_wr_en),
        .imm_o     (dec_imm)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_i (rst_i),
        .wb_i  (wb_i),
        .ra1_i (rs_addr),
        .ra2_i (rt_addr),
        .rd1_o (rs_data),
        .rd2_o (rt_data)
    );

    operand_mux u_op1_mux (
        .re_i      (rs_re),
        .addr_i    (rs_addr),
        .rf_data_i (rs_data),
        .imm_i     (dec_imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_mux u_op2_mux (
        .re_i      (rt_re),
        .addr_i    (rt_addr),
        .rf_data_i (rt_data),
        .imm_i     (dec_imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    // single-entry output register
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            bundle_o    <= '0;
        end else if (accept) begin
            out_valid_o      <= 1'b1;
            bundle_o.alu_op  <= dec_alu_op;
            bundle_o.alu_sel <= dec_alu_sel;
            bundle_o.op1     <= op1;
            bundle_o.op2     <= op2;
            bundle_o.wr_addr <= dec_wr_addr;
            bundle_o.wr_en   <= dec_wr_en;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(bundle_o));

    a_reset_empty: assert property (@(posedge clk) rst_i |=> !out_valid_o);

    a_shift_not_add: assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && (bundle_o.alu_sel == mips_pkg::SEL_SHIFT)
            |-> bundle_o.alu_op != mips_pkg::ALU_ADD);

endmodule

//--- verilog/reg_file.sv
/*
 * Register file
 * 32 x 32, two combinational read ports, one write port,
 * same-cycle write data bypassed to the readers
 */
`timescale 1ns/1ps
`include "mips_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_i,
    input  mips_pkg::reg_wr_t       wb_i,
    input  logic [`MIPS_REG_AW-1:0] ra1_i,
    input  logic [`MIPS_REG_AW-1:0] ra2_i,
    output logic [`MIPS_DATA_W-1:0] rd1_o,
    output logic [`MIPS_DATA_W-1:0] rd2_o
);

    localparam int NUM_REGS = 1 << `MIPS_REG_AW;

    logic [`MIPS_DATA_W-1:0] regs [NUM_REGS];
    logic                    wr_store;

    assign wr_store = wb_i.en && (wb_i.addr != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_store) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    always_comb begin
        if (ra1_i == '0) begin
            rd1_o = '0;
        end else if (wr_store && (wb_i.addr == ra1_i)) begin
            rd1_o = wb_i.data;
        end else begin
            rd1_o = regs[ra1_i];
        end
    end

    always_comb begin
        if (ra2_i == '0) begin
            rd2_o = '0;
        end else if (wr_store && (wb_i.addr == ra2_i)) begin
            rd2_o = wb_i.data;
        end else begin
            rd2_o = regs[ra2_i];
        end
    end

    // r0 storage stays clear across any writeback traffic
    a_r0_clear: assert property (@(posedge clk) disable iff (rst_i) regs[0] == '0);

endmodule

//--- vlog.f
+incdir+common
+incdir+tb
common/mips_pkg.sv
decode/inst_decoder.sv
decode/operand_mux.sv
verilog/reg_file.sv
verilog/id_stage.sv
tb/tb_id_stage.sv
